//--- compile.f
design/tester_pkg.sv
design/cmd_decoder.sv
design/vector_store.sv
design/cycle_timer.sv
design/vector_tester_top.sv
verification/tb_vector_tester.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_vector_tester
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_vector_tester.sv
`timescale 1ns/1ps

module tb_vector_tester;

	import tester_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int IDX_W         = $clog2(VEC_DEPTH);
	localparam int RUN1_LE       = 2;
	localparam int RUN1_TE       = 5;
	localparam int RUN1_LEN      = 6;
	localparam int RUN1_VECS     = 3;
	localparam int RUN2_LE       = 0;
	localparam int RUN2_TE       = 3;
	localparam int RUN2_LEN      = 3;
	localparam int RUN2_WRITES   = VEC_DEPTH + 1;
	localparam int MARGIN_CYCLES = 600;
	localparam int WATCH_CYCLES  = RUN1_VECS * (RUN1_LEN + 1) +
	                               VEC_DEPTH * (RUN2_LEN + 1) + MARGIN_CYCLES;

	logic             CLK = 1'b0;
	logic             rst;
	logic             cmd_valid;
	logic             cmd_ready;
	logic [VEC_W-1:0] cmd_data;
	logic             rsp_valid;
	logic             rsp_ready;
	rsp_e             rsp_code;
	logic [VEC_W-1:0] signals;
	logic             strobe;
	logic             test_active;

	// Model of the store contents and the latched configuration.
	logic [VEC_W-1:0] model_vecs [VEC_DEPTH];
	int               model_n;
	int               cfg_le;
	int               cfg_te;
	int               cfg_len;
	rsp_e             exp_rsp;
	logic             exp_run;

	logic             hold_rsp;
	logic             rsp_ok = 1'b0;
	logic [16:0]      vec_lfsr = 17'd72836;
	logic [16:0]      stall_lfsr = 17'd72836;
	logic [1:0]       stall_bits;

	int               run_clk;
	int               cyc_len;
	int               exp_cnt;
	int               exp_idx;
	logic             exp_strobe;
	logic             run_last;
	logic [VEC_W-1:0] exp_vec;
	int               mismatches = 0;
	int               timeouts = 0;

	vector_tester_top i_dut (
		.CLK         (CLK),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_data    (cmd_data),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp_code    (rsp_code),
		.signals     (signals),
		.strobe      (strobe),
		.test_active (test_active)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	//////////////////////////////
	// Random bits
	//////////////////////////////

	// x^17 + x^14 + 1, maximal length.
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	function automatic logic [VEC_W-1:0] take_bits(input int n);
		logic [VEC_W-1:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			vec_lfsr = lfsr_next(vec_lfsr);
			v = {v[VEC_W-2:0], vec_lfsr[0]};
		end
		return v;
	endfunction

	// Two bits a clock, so the host holds off about one clock in four.
	always @(negedge CLK) begin
		stall_lfsr = lfsr_next(stall_lfsr);
		stall_bits[0] = stall_lfsr[0];
		stall_lfsr = lfsr_next(stall_lfsr);
		stall_bits[1] = stall_lfsr[0];
		rsp_ok <= (stall_bits != 2'b00);
	end

	assign rsp_ready = rsp_ok && !hold_rsp;

	//////////////////////////////
	// Expected run outputs
	//////////////////////////////

	// Clocks since the test_active rise.
	always @(posedge CLK) begin
		if (rst || !test_active) begin
			run_clk <= 0;
		end else begin
			run_clk <= run_clk + 1;
		end
	end

	always_comb begin
		cyc_len    = cfg_len + 1;
		exp_cnt    = run_clk % cyc_len;
		exp_idx    = run_clk / cyc_len;
		exp_strobe = (exp_cnt >= cfg_le) && (exp_cnt < cfg_te);
		run_last   = (run_clk == model_n * cyc_len - 1);
		exp_vec    = (exp_idx < model_n) ? model_vecs[exp_idx[IDX_W-1:0]] : '0;
	end

	function automatic void note_mismatch(input string msg);
		mismatches++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endfunction

	a_rsp_latency: assert property (@(posedge CLK) disable iff (rst)
		cmd_valid && cmd_ready && !exp_run |=> rsp_valid && rsp_code == exp_rsp)
		else note_mismatch("wrong or missing response one clock after a command");
	a_rsp_stall: assert property (@(posedge CLK) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_code))
		else note_mismatch("stalled response changed");
	a_cmd_blocked: assert property (@(posedge CLK) disable iff (rst)
		rsp_valid || test_active |-> !cmd_ready)
		else note_mismatch("cmd_ready high during a response or a run");
	a_vector: assert property (@(posedge CLK) disable iff (rst)
		test_active |-> signals == exp_vec)
		else note_mismatch("signals differ from the expected vector");
	a_strobe_win: assert property (@(posedge CLK) disable iff (rst)
		test_active |-> strobe == exp_strobe)
		else note_mismatch("strobe outside its window");
	a_idle_outputs: assert property (@(posedge CLK) disable iff (rst)
		!test_active |-> !strobe && signals == '0)
		else note_mismatch("strobe or signals active outside a run");
	a_run_hold: assert property (@(posedge CLK) disable iff (rst)
		test_active && !run_last |=> test_active)
		else note_mismatch("run ended early");
	a_run_end: assert property (@(posedge CLK) disable iff (rst)
		test_active && run_last |=> !test_active && signals == '0)
		else note_mismatch("run did not end after the last test cycle");
	a_run_rsp: assert property (@(posedge CLK) disable iff (rst)
		$fell(test_active) |=> rsp_valid && rsp_code == RSP_ACK)
		else note_mismatch("no acknowledge one clock after the run");

	//////////////////////////////
	// Host tasks
	//////////////////////////////

	// Sends one word and returns on the edge that takes its response.
	task automatic send_word(input logic [VEC_W-1:0] word, input rsp_e rsp,
	                         input logic run, input int stall);
		@(negedge CLK);
		cmd_valid = 1'b1;
		cmd_data  = word;
		exp_rsp   = rsp;
		exp_run   = run;
		hold_rsp  = (stall > 0);
		do begin
			@(posedge CLK);
		end while (!cmd_ready);
		@(negedge CLK);
		cmd_valid = 1'b0;
		repeat (stall) @(negedge CLK);
		hold_rsp = 1'b0;
		do begin
			@(posedge CLK);
		end while (!(rsp_valid && rsp_ready));
	endtask

	task automatic set_config(input int le, input int te, input int len);
		logic [VEC_W-1:0] word;
		word = '0;
		word[7:0] = OP_CYCLE_CONFIG;
		word[LE_LSB +: TIME_W]  = TIME_W'(le);
		word[TE_LSB +: TIME_W]  = TIME_W'(te);
		word[LEN_LSB +: TIME_W] = TIME_W'(len);
		cfg_le  = le;
		cfg_te  = te;
		cfg_len = len;
		send_word(word, RSP_ACK, 1'b0, 1);
	endtask

	task automatic write_vector(input logic [VEC_W-1:0] data);
		logic [VEC_W-1:0] hdr;
		hdr = '0;
		hdr[7:0] = OP_INPUT_HDR;
		send_word(hdr, RSP_ACK, 1'b0, 0);
		send_word(data, RSP_ACK, 1'b0, 0);
		// A full store drops the word.
		if (model_n < VEC_DEPTH) begin
			model_vecs[model_n[IDX_W-1:0]] = data;
			model_n++;
		end
	endtask

	task automatic run_execute();
		logic [VEC_W-1:0] word;
		word = '0;
		word[7:0] = OP_EXECUTE;
		if (model_n == 0) begin
			send_word(word, RSP_NO_VECTORS, 1'b0, 2);
		end else begin
			send_word(word, RSP_ACK, 1'b1, 0);
			model_n = 0;
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		logic [VEC_W-1:0] unknown;
		rst       = 1'b1;
		cmd_valid = 1'b0;
		cmd_data  = '0;
		hold_rsp  = 1'b0;
		exp_rsp   = RSP_ACK;
		exp_run   = 1'b0;
		model_n   = 0;
		cfg_le    = 0;
		cfg_te    = 0;
		cfg_len   = 0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		@(posedge CLK);

		run_execute();
		unknown = take_bits(VEC_W);
		unknown[7:0] = 8'h42;
		send_word(unknown, RSP_UNKNOWN, 1'b0, 4);

		set_config(RUN1_LE, RUN1_TE, RUN1_LEN);
		repeat (RUN1_VECS) write_vector(take_bits(VEC_W));
		run_execute();
		run_execute();

		// Strobe opens at count 0; the last write overflows the store.
		set_config(RUN2_LE, RUN2_TE, RUN2_LEN);
		repeat (RUN2_WRITES) write_vector(take_bits(VEC_W));
		run_execute();

		repeat (2) @(posedge CLK);
		$display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		timeouts = 1;
		$display("Timeout: command sequence did not finish within %0d cycles", WATCH_CYCLES);
		$display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- design/vector_tester_top.sv
`timescale 1ns/1ps

module vector_tester_top (
	input  logic                            CLK,
	input  logic                            rst,
	input  logic                            cmd_valid,
	output logic                            cmd_ready,
	input  logic [tester_pkg::VEC_W-1:0]    cmd_data,
	output logic                            rsp_valid,
	input  logic                            rsp_ready,
	output tester_pkg::rsp_e                rsp_code,
	output logic [tester_pkg::VEC_W-1:0]    signals,
	output logic                            strobe,
	output logic                            test_active
);

	import tester_pkg::*;

	// Decoder to store.
	logic             wr_en;
	logic [VEC_W-1:0] wr_data;
	logic [PTR_W-1:0] vec_count;

	// Decoder to timer.
	logic              run_start;
	logic              run_done;
	logic [TIME_W-1:0] le;
	logic [TIME_W-1:0] te;
	logic [TIME_W-1:0] len;

	// Store read port.
	logic             vec_valid;
	logic             vec_ready;
	logic [VEC_W-1:0] vec_data;

	cmd_decoder u_decoder (
		.CLK       (CLK),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_data  (cmd_data),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_code  (rsp_code),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.vec_count (vec_count),
		.run_start (run_start),
		.run_done  (run_done),
		.le        (le),
		.te        (te),
		.len       (len)
	);

	// The end of a run empties the store.
	vector_store u_store (
		.CLK       (CLK),
		.rst       (rst),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.vec_count (vec_count),
		.vec_valid (vec_valid),
		.vec_ready (vec_ready),
		.vec_data  (vec_data),
		.clear     (run_done)
	);

	cycle_timer u_timer (
		.CLK         (CLK),
		.rst         (rst),
		.run_start   (run_start),
		.le          (le),
		.te          (te),
		.len         (len),
		.vec_valid   (vec_valid),
		.vec_ready   (vec_ready),
		.vec_data    (vec_data),
		.signals     (signals),
		.strobe      (strobe),
		.test_active (test_active),
		.run_done    (run_done)
	);

endmodule

//--- design/cycle_timer.sv
`timescale 1ns/1ps

module cycle_timer (
	input  logic                            CLK,
	input  logic                            rst,
	input  logic                            run_start,
	input  logic [tester_pkg::TIME_W-1:0]   le,
	input  logic [tester_pkg::TIME_W-1:0]   te,
	input  logic [tester_pkg::TIME_W-1:0]   len,
	input  logic                            vec_valid,
	output logic                            vec_ready,
	input  logic [tester_pkg::VEC_W-1:0]    vec_data,
	output logic [tester_pkg::VEC_W-1:0]    signals,
	output logic                            strobe,
	output logic                            test_active,
	output logic                            run_done
);

	import tester_pkg::*;

	logic [TIME_W-1:0] count;
	logic [TIME_W-1:0] cnt_nxt;
	logic              active_nxt;
	logic              boundary;
	logic              take;
	logic              finish;

	//////////////////////////////
	// Test-cycle sequencing
	//////////////////////////////

	// A boundary is the run start or the last clock of a test cycle.
	assign boundary = (run_start && !test_active) ||
	                  (test_active && count == len);
	assign take     = boundary && vec_valid;
	assign finish   = boundary && !vec_valid;

	// The store advances on the same edge that loads the bus.
	assign vec_ready = take;

	always_comb begin
		cnt_nxt    = count;
		active_nxt = test_active;
		if (boundary) begin
			cnt_nxt    = '0;
			active_nxt = vec_valid;
		end else if (test_active) begin
			cnt_nxt = count + TIME_W'(1);
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			count       <= '0;
			test_active <= 1'b0;
			strobe      <= 1'b0;
			run_done    <= 1'b0;
			signals     <= '0;
		end else begin
			count       <= cnt_nxt;
			test_active <= active_nxt;
			run_done    <= finish;

			// Window le <= c < te, registered against the next count.
			strobe <= active_nxt && (cnt_nxt >= le) && (cnt_nxt < te);

			if (take) begin
				signals <= vec_data;
			end else if (finish) begin
				signals <= '0;
			end
		end
	end

	// Strobe only pulses inside an active run.
	a_strobe_in_run: assert property (@(posedge CLK) disable iff (rst)
		strobe |-> test_active);

endmodule

//--- design/vector_store.sv
`timescale 1ns/1ps

module vector_store (
	input  logic                            CLK,
	input  logic                            rst,
	input  logic                            wr_en,
	input  logic [tester_pkg::VEC_W-1:0]    wr_data,
	output logic [tester_pkg::PTR_W-1:0]    vec_count,
	output logic                            vec_valid,
	input  logic                            vec_ready,
	output logic [tester_pkg::VEC_W-1:0]    vec_data,
	input  logic                            clear
);

	import tester_pkg::*;

	logic [VEC_W-1:0] mem [VEC_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] rd_nxt;

	// Read pointer after this clock's take.
	assign rd_nxt    = rd_ptr + PTR_W'(vec_ready);
	assign vec_count = wr_ptr - rd_ptr;

	//////////////////////////////
	// Pointers
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst || clear) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			vec_valid <= 1'b0;
		end else begin
			// Writes beyond the last entry are lost.
			if (wr_en && wr_ptr < PTR_W'(VEC_DEPTH)) begin
				wr_ptr <= wr_ptr + PTR_W'(1);
			end
			rd_ptr    <= rd_nxt;
			vec_valid <= (rd_nxt < wr_ptr);
		end
	end

	//////////////////////////////
	// Storage and read data
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (wr_en && wr_ptr < PTR_W'(VEC_DEPTH)) begin
			mem[wr_ptr[$clog2(VEC_DEPTH)-1:0]] <= wr_data;
		end
		// Word presented next; stale when rd_nxt has run past the end.
		vec_data <= mem[rd_nxt[$clog2(VEC_DEPTH)-1:0]];
	end

	// The timer only takes a vector that is being offered.
	a_no_empty_take: assert property (@(posedge CLK) disable iff (rst)
		vec_ready |-> vec_valid);

endmodule

//--- design/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
	input  logic                            CLK,
	input  logic                            rst,
	input  logic                            cmd_valid,
	output logic                            cmd_ready,
	input  logic [tester_pkg::VEC_W-1:0]    cmd_data,
	output logic                            rsp_valid,
	input  logic                            rsp_ready,
	output tester_pkg::rsp_e                rsp_code,
	output logic                            wr_en,
	output logic [tester_pkg::VEC_W-1:0]    wr_data,
	input  logic [tester_pkg::PTR_W-1:0]    vec_count,
	output logic                            run_start,
	input  logic                            run_done,
	output logic [tester_pkg::TIME_W-1:0]   le,
	output logic [tester_pkg::TIME_W-1:0]   te,
	output logic [tester_pkg::TIME_W-1:0]   len
);

	import tester_pkg::*;

	dec_state_e state;
	opcode_e    op;
	rsp_e       rsp_nxt;
	logic       accept;
	logic       after_hdr;

	assign op     = opcode_e'(cmd_data[7:0]);
	assign accept = cmd_valid && cmd_ready;

	// Response for the word being accepted this clock.
	always_comb begin
		if (state == ST_WAIT_VEC) begin
			rsp_nxt = RSP_ACK;
		end else begin
			case (op)
				OP_INPUT_HDR,
				OP_CYCLE_CONFIG: rsp_nxt = RSP_ACK;
				OP_EXECUTE:      rsp_nxt = (vec_count == '0) ? RSP_NO_VECTORS : RSP_ACK;
				default:         rsp_nxt = RSP_UNKNOWN;
			endcase
		end
	end

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state     <= ST_IDLE;
			cmd_ready <= 1'b0;
			rsp_valid <= 1'b0;
			wr_en     <= 1'b0;
			run_start <= 1'b0;
			after_hdr <= 1'b0;
		end else begin
			wr_en     <= 1'b0;
			run_start <= 1'b0;

			case (state)
				ST_IDLE: begin
					cmd_ready <= 1'b1;
					if (accept) begin
						cmd_ready <= 1'b0;
						if (op == OP_EXECUTE && vec_count != '0) begin
							// Response waits for the end of the run.
							run_start <= 1'b1;
							state     <= ST_RUNNING;
						end else begin
							rsp_valid <= 1'b1;
							after_hdr <= (op == OP_INPUT_HDR);
							state     <= ST_RESPOND;
						end
					end
				end

				ST_WAIT_VEC: begin
					cmd_ready <= 1'b1;
					if (accept) begin
						cmd_ready <= 1'b0;
						wr_en     <= 1'b1;
						rsp_valid <= 1'b1;
						state     <= ST_RESPOND;
					end
				end

				ST_RESPOND: begin
					if (rsp_ready) begin
						rsp_valid <= 1'b0;
						cmd_ready <= 1'b1;
						after_hdr <= 1'b0;
						state     <= after_hdr ? ST_WAIT_VEC : ST_IDLE;
					end
				end

				ST_RUNNING: begin
					if (run_done) begin
						rsp_valid <= 1'b1;
						state     <= ST_RUN_RSP;
					end
				end

				ST_RUN_RSP: begin
					if (rsp_ready) begin
						rsp_valid <= 1'b0;
						cmd_ready <= 1'b1;
						state     <= ST_IDLE;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// Payload registers
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (accept) begin
			rsp_code <= rsp_nxt;
		end else if (state == ST_RUNNING && run_done) begin
			rsp_code <= RSP_ACK;
		end

		if (accept && state == ST_WAIT_VEC) begin
			wr_data <= cmd_data;
		end

		// Timing fields of a configuration word.
		if (accept && state == ST_IDLE && op == OP_CYCLE_CONFIG) begin
			le  <= cmd_data[LE_LSB +: TIME_W];
			te  <= cmd_data[TE_LSB +: TIME_W];
			len <= cmd_data[LEN_LSB +: TIME_W];
		end
	end

	// A stalled response must not change under the host.
	a_rsp_stable: assert property (@(posedge CLK) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_code));

endmodule

//--- design/tester_pkg.sv
package tester_pkg;

	//////////////////////////////
	// Widths and sizes
	//////////////////////////////

	// Command word, vector and signal bus width.
	localparam int VEC_W = 128;

	// Number of vectors held by the store.
	localparam int VEC_DEPTH = 8;

	// Pointers and count must reach VEC_DEPTH itself.
	localparam int PTR_W = 4;

	// Timing fields and the in-cycle counter.
	localparam int TIME_W = 8;

	//////////////////////////////
	// Configuration word layout
	//////////////////////////////

	localparam int LE_LSB  = 8;
	localparam int TE_LSB  = 24;
	localparam int LEN_LSB = 32;

	//////////////////////////////
	// Host codes
	//////////////////////////////

	// Opcode sits in the low byte of a command word.
	typedef enum logic [7:0] {
		OP_INPUT_HDR    = 8'h11,
		OP_CYCLE_CONFIG = 8'h15,
		OP_EXECUTE      = 8'h16
	} opcode_e;

	typedef enum logic [7:0] {
		RSP_ACK        = 8'hA5,
		RSP_UNKNOWN    = 8'hE1,
		RSP_NO_VECTORS = 8'hE2
	} rsp_e;

	// Command decoder states.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT_VEC,
		ST_RESPOND,
		ST_RUNNING,
		ST_RUN_RSP
	} dec_state_e;

endpackage
